//--- hdl/adc_frontend.sv
/*
 * adc input stage
 * registers both raw words, drops the reserved lsbs and turns the
 * negative slope offset code into two's complement. digital loop
 * replaces the pins with the dac pair
 */
`timescale 1ns/1ps
`default_nettype none

`include "rp_settings.svh"

module adc_frontend (
  input  wire                  adc_clk,
  input  wire                  rst_n_i,
  input  rp_pkg::raw_pair_t    adc_raw_i,
  input  wire                  digital_loop_i,
  input  rp_pkg::sample_pair_t loop_pair_i,
  output rp_pkg::sample_pair_t adc_pair_o
);

  import rp_pkg::*;

  raw_pair_t raw_q;   // io register

  // keep msb, invert the rest
  function automatic sample_t raw_to_sample(raw_t raw);
    logic [`RP_ADC_BITS-1:0] code;
    code = raw[`RP_RAW_BITS-1:`RP_RAW_BITS-`RP_ADC_BITS];  // 2 lsbs reserved
    return {code[`RP_ADC_BITS-1], ~code[`RP_ADC_BITS-2:0]};
  endfunction

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      raw_q <= '0;
    else
      raw_q <= adc_raw_i;
  end

  // loop path stays combinational, router register breaks it
  assign adc_pair_o.a = digital_loop_i ? loop_pair_i.a : raw_to_sample(raw_q.a);
  assign adc_pair_o.b = digital_loop_i ? loop_pair_i.b : raw_to_sample(raw_q.b);

endmodule

`default_nettype wire

//--- hdl/dac_backend.sv
/*
 * dac output stage
 * converts back to negative slope code and interleaves both channels
 * on one 14 bit bus with channel a while dac_sel_o is low and
 * channel b while high
 */
`timescale 1ns/1ps
`default_nettype none

module dac_backend (
  input  wire                  adc_clk,
  input  wire                  rst_n_i,
  input  rp_pkg::sample_pair_t dac_pair_i,
  output rp_pkg::dac_code_t    dac_dat_o,
  output logic                 dac_sel_o,
  output logic                 dac_rst_o
);

  import rp_pkg::*;

  dac_code_t code_b_q;   // b half of the pair taken with a

  function automatic dac_code_t to_dac(sample_t s);
    return {s[$bits(s)-1], ~s[$bits(s)-2:0]};
  endfunction

  // pair is sampled only in the cycle before sel drops to 0
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_sel_o <= 1'b0;
      dac_dat_o <= '0;
      code_b_q  <= '0;
    end
    else
    begin
      dac_sel_o <= ~dac_sel_o;                // toggles every cycle
      if (dac_sel_o)
      begin
        dac_dat_o <= to_dac(dac_pair_i.a);   // a phase next
        code_b_q  <= to_dac(dac_pair_i.b);
      end
      else
        dac_dat_o <= code_b_q;               // b of the same pair
    end
  end

  // dac reset released one cycle after rst_n_i
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      dac_rst_o <= 1'b1;
    else
      dac_rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- hdl/housekeeping.sv
/*
 * housekeeping registers, bus region 0
 * read only id word, digital loop enable and led drive
 */
`timescale 1ns/1ps
`default_nettype none

`include "rp_settings.svh"

module housekeeping (
  input  wire              adc_clk,
  input  wire              rst_n_i,
  input  rp_pkg::sys_req_t req_i,
  output rp_pkg::sys_rsp_t rsp_o,
  output logic             digital_loop_o,
  output logic [7:0]       led_o
);

  import rp_pkg::*;

  logic [`RP_REGION_LSB-1:0] offs;     // offset inside the region
  logic [31:0]               rd_mux;

  assign offs = req_i.addr[`RP_REGION_LSB-1:0];

  //////////////////////////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
    end
    else if (req_i.wen)
    begin
      case (offs)
        `RP_REG_LOOP: digital_loop_o <= req_i.wdata[0];
        `RP_REG_LED:  led_o          <= req_i.wdata[7:0];
        default:      ;   // id is read only
      endcase
    end
  end

  // read data, zero extended
  always_comb
  begin
    case (offs)
      `RP_REG_ID:   rd_mux = `RP_HK_ID;
      `RP_REG_LOOP: rd_mux = {31'b0, digital_loop_o};
      `RP_REG_LED:  rd_mux = {24'b0, led_o};
      default:      rd_mux = '0;
    endcase
  end

  // response one cycle after the strobe
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rsp_o <= '0;
    else
    begin
      rsp_o.ack   <= req_i.wen | req_i.ren;
      rsp_o.err   <= req_i.wen && (offs == `RP_REG_ID);  // write to id
      rsp_o.rdata <= req_i.ren ? rd_mux : '0;
    end
  end

  a_ack_single: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    rsp_o.ack |=> !rsp_o.ack);

endmodule

`default_nettype wire

//--- hdl/output_router.sv
/*
 * output router, bus region 3
 * reduced dsp block: each dac channel takes adc a, adc b,
 * a bus written set value or zero, registered every cycle
 */
`timescale 1ns/1ps
`default_nettype none

`include "rp_settings.svh"

module output_router (
  input  wire                  adc_clk,
  input  wire                  rst_n_i,
  input  rp_pkg::sys_req_t     req_i,
  input  rp_pkg::sample_pair_t adc_pair_i,
  output rp_pkg::sys_rsp_t     rsp_o,
  output rp_pkg::sample_pair_t out_pair_o
);

  import rp_pkg::*;

  logic [`RP_REGION_LSB-1:0] offs;
  logic [31:0]               rd_mux;
  src_sel_t                  sel_a, sel_b;
  sample_t                   set_a, set_b;

  assign offs = req_i.addr[`RP_REGION_LSB-1:0];

  function automatic sample_t pick(src_sel_t sel, sample_pair_t adc, sample_t set);
    case (sel)
      SRC_ADC_A: return adc.a;
      SRC_ADC_B: return adc.b;
      SRC_SET:   return set;
      default:   return '0;   // SRC_ZERO
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sel_a <= SRC_ADC_A;
      sel_b <= SRC_ADC_A;
      set_a <= '0;
      set_b <= '0;
    end
    else if (req_i.wen)
    begin
      case (offs)
        `RP_REG_SEL_A: sel_a <= src_sel_t'(req_i.wdata[1:0]);
        `RP_REG_SEL_B: sel_b <= src_sel_t'(req_i.wdata[1:0]);
        `RP_REG_SET_A: set_a <= req_i.wdata[`RP_ADC_BITS-1:0];
        `RP_REG_SET_B: set_b <= req_i.wdata[`RP_ADC_BITS-1:0];
        default:       ;
      endcase
    end
  end

  always_comb
  begin
    case (offs)
      `RP_REG_SEL_A: rd_mux = {30'b0, sel_a};
      `RP_REG_SEL_B: rd_mux = {30'b0, sel_b};
      `RP_REG_SET_A: rd_mux = {{(32-`RP_ADC_BITS){1'b0}}, set_a};  // no sign ext
      `RP_REG_SET_B: rd_mux = {{(32-`RP_ADC_BITS){1'b0}}, set_b};
      default:       rd_mux = '0;
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rsp_o <= '0;
    else
    begin
      rsp_o.ack   <= req_i.wen | req_i.ren;
      rsp_o.err   <= 1'b0;                        // nothing read only here
      rsp_o.rdata <= req_i.ren ? rd_mux : '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sample path
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      out_pair_o <= '0;
    else
    begin
      out_pair_o.a <= pick(sel_a, adc_pair_i, set_a);
      out_pair_o.b <= pick(sel_b, adc_pair_i, set_b);
    end
  end

endmodule

`default_nettype wire

//--- hdl/rp_analog_top.sv
/*
 * analog board controller top
 * bus decoder with housekeeping and router slaves beside the
 * adc -> router -> dac sample path, all on adc_clk
 */
`timescale 1ns/1ps
`default_nettype none

module rp_analog_top (
  input  wire                  adc_clk,
  input  wire                  rst_n_i,
  input  rp_pkg::raw_pair_t    adc_raw_i,
  input  rp_pkg::sys_req_t     sys_req_i,
  output rp_pkg::sys_rsp_t     sys_rsp_o,
  output rp_pkg::dac_code_t    dac_dat_o,
  output logic                 dac_sel_o,
  output logic                 dac_rst_o,
  output logic [7:0]           led_o
);

  import rp_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////////////////////////

  sys_req_t     hk_req, router_req;
  sys_rsp_t     hk_rsp, router_rsp;
  logic         digital_loop;
  sample_pair_t adc_pair;     // two's complement from the pins or loop
  sample_pair_t dac_pair;     // router output

  sys_bus_decoder i_dec (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .sys_req_i    (sys_req_i),
    .hk_rsp_i     (hk_rsp),
    .router_rsp_i (router_rsp),
    .hk_req_o     (hk_req),
    .router_req_o (router_req),
    .sys_rsp_o    (sys_rsp_o)
  );

  housekeeping i_hk (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .req_i          (hk_req),
    .rsp_o          (hk_rsp),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  //////////////////////////////////////////////////////////////////////
  // sample path
  //////////////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_raw_i      (adc_raw_i),
    .digital_loop_i (digital_loop),
    .loop_pair_i    (dac_pair),     // back into the adc path
    .adc_pair_o     (adc_pair)
  );

  output_router i_router (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .req_i      (router_req),
    .adc_pair_i (adc_pair),
    .rsp_o      (router_rsp),
    .out_pair_o (dac_pair)
  );

  dac_backend i_dac (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .dac_pair_i (dac_pair),
    .dac_dat_o  (dac_dat_o),
    .dac_sel_o  (dac_sel_o),
    .dac_rst_o  (dac_rst_o)
  );

endmodule

`default_nettype wire

//--- hdl/rp_pkg.sv
/*
 * analog board controller types
 * samples and sample pairs, raw adc words, dac codes,
 * system bus request and response, router source select
 */
`default_nettype none

`include "rp_settings.svh"

package rp_pkg;

  // data path
  typedef logic signed [`RP_ADC_BITS-1:0] sample_t;   // two's complement
  typedef logic        [`RP_RAW_BITS-1:0] raw_t;      // as on the pins
  typedef logic        [`RP_ADC_BITS-1:0] dac_code_t; // negative slope, unsigned

  typedef struct packed {
    sample_t a;     // channel 1
    sample_t b;     // channel 2
  } sample_pair_t;

  typedef struct packed {
    raw_t a;
    raw_t b;
  } raw_pair_t;

  // system bus
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  sel;    // byte select
    logic        wen;    // one cycle strobe
    logic        ren;    // one cycle strobe
  } sys_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
    logic        ack;
  } sys_rsp_t;

  typedef logic [`RP_REGION_MSB-`RP_REGION_LSB:0] region_t;

  // per channel output source
  typedef enum logic [1:0] {
    SRC_ADC_A = 2'd0,
    SRC_ADC_B = 2'd1,
    SRC_SET   = 2'd2,
    SRC_ZERO  = 2'd3
  } src_sel_t;

endpackage

`default_nettype wire

//--- hdl/sys_bus_decoder.sv
/*
 * system bus decoder
 * splits the address space into eight regions on addr[22:20],
 * steers strobes to housekeeping and router, muxes the response back.
 * unused regions answer zero data with an immediate ack
 */
`timescale 1ns/1ps
`default_nettype none

`include "rp_settings.svh"

module sys_bus_decoder (
  input  wire              adc_clk,
  input  wire              rst_n_i,
  input  rp_pkg::sys_req_t sys_req_i,
  input  rp_pkg::sys_rsp_t hk_rsp_i,
  input  rp_pkg::sys_rsp_t router_rsp_i,
  output rp_pkg::sys_req_t hk_req_o,
  output rp_pkg::sys_req_t router_req_o,
  output rp_pkg::sys_rsp_t sys_rsp_o
);

  import rp_pkg::*;

  region_t                  region;
  logic [`RP_N_REGIONS-1:0] region_cs;   // one hot
  logic                     strobe;
  logic                     pend_q;      // strobe issued, ack outstanding

  assign region    = sys_req_i.addr[`RP_REGION_MSB:`RP_REGION_LSB];
  assign region_cs = `RP_N_REGIONS'(1) << region;
  assign strobe    = sys_req_i.wen | sys_req_i.ren;

  //////////////////////////////////////////////////////////////////////
  // request fan out, strobes only reach the selected slave
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    hk_req_o         = sys_req_i;
    hk_req_o.wen     = sys_req_i.wen & region_cs[`RP_HK_REGION];
    hk_req_o.ren     = sys_req_i.ren & region_cs[`RP_HK_REGION];
    router_req_o     = sys_req_i;
    router_req_o.wen = sys_req_i.wen & region_cs[`RP_ROUTER_REGION];
    router_req_o.ren = sys_req_i.ren & region_cs[`RP_ROUTER_REGION];
  end

  // response mux, address is held until ack
  always_comb
  begin
    unique case (region)
      region_t'(`RP_HK_REGION):     sys_rsp_o = hk_rsp_i;
      region_t'(`RP_ROUTER_REGION): sys_rsp_o = router_rsp_i;
      default:
      begin
        sys_rsp_o       = '0;     // empty slave
        sys_rsp_o.ack   = strobe;  // same cycle
      end
    endcase
  end

  // outstanding transfer tracking
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      pend_q <= 1'b0;
    else if (pend_q)
      pend_q <= !sys_rsp_o.ack;
    else
      pend_q <= strobe && !sys_rsp_o.ack;
  end

  //////////////////////////////////////////////////////////////////////
  // bus protocol checks
  //////////////////////////////////////////////////////////////////////

  a_no_rw_overlap: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    !(sys_req_i.wen && sys_req_i.ren));

  a_one_outstanding: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    strobe |-> !pend_q);  // master waits for ack

endmodule

`default_nettype wire

//--- include/rp_settings.svh
/*
 * analog board controller settings
 * sample widths, system bus region map, register offsets and the ID word
 */
`ifndef RP_SETTINGS_SVH
`define RP_SETTINGS_SVH

// data path widths
`define RP_ADC_BITS       14          // sample width
`define RP_RAW_BITS       16          // raw adc word, two reserved lsbs

// system bus region map
`define RP_REGION_MSB     22
`define RP_REGION_LSB     20          // offset field is everything below
`define RP_N_REGIONS      8
`define RP_HK_REGION      0           // housekeeping
`define RP_ROUTER_REGION  3           // output router (reduced dsp)

// housekeeping offsets
`define RP_REG_ID         20'h00000
`define RP_REG_LOOP       20'h00004
`define RP_REG_LED        20'h00008

// router offsets
`define RP_REG_SEL_A      20'h00000
`define RP_REG_SEL_B      20'h00004
`define RP_REG_SET_A      20'h00008
`define RP_REG_SET_B      20'h0000C

`define RP_HK_ID          32'h5250_0a01  // board id word, read only

`endif

//--- test/tb_rp_analog_top.sv
/*
 * testbench for the analog board controller top
 * bus transfers on the system bus, random adc words through the
 * router and dac interleave, reference model for the dac codes
 */
`timescale 1ns/1ps
`default_nettype none

`include "rp_settings.svh"

module tb_rp_analog_top;

  import rp_pkg::*;

  localparam int N_PAIRS         = 20;                 // per select setting
  localparam int WATCHDOG_CYCLES = 4 * N_PAIRS * 16 + 720;

  logic      adc_clk, rst_n_i;
  raw_pair_t adc_raw_i;
  sys_req_t  sys_req_i;
  sys_rsp_t  sys_rsp_o;
  dac_code_t dac_dat_o;
  logic      dac_sel_o, dac_rst_o;
  logic [7:0] led_o;

  // tb mirror of the dut configuration
  src_sel_t  sel_a, sel_b;
  sample_t   set_a, set_b;
  logic      loop_on;
  logic [31:0] lfsr_q = 32'hf97e;
  logic      check_en;
  dac_code_t exp_a, exp_b;
  string     cur_test;
  int        errors, checks, tests_run, tests_failed, err_mark, chk_mark;

  rp_analog_top uut (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .adc_raw_i (adc_raw_i),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_rst_o (dac_rst_o),
    .led_o     (led_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;   // 25 MHz
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // drops the reserved lsbs, keeps the msb and inverts the rest
  function automatic sample_t adc_sample(raw_t raw);
    logic [`RP_ADC_BITS-1:0] code;
    code = raw[`RP_RAW_BITS-1:2];
    return {code[`RP_ADC_BITS-1], ~code[`RP_ADC_BITS-2:0]};
  endfunction

  function automatic dac_code_t dac_code(sample_t s);
    return {s[`RP_ADC_BITS-1], ~s[`RP_ADC_BITS-2:0]};
  endfunction

  function automatic sample_t route(src_sel_t sel, sample_t a, sample_t b, sample_t set_v);
    case (sel)
      SRC_ADC_A: return a;
      SRC_ADC_B: return b;
      SRC_SET:   return set_v;
      default:   return '0;
    endcase
  endfunction

  function automatic dac_code_t expected_code(raw_pair_t raw, src_sel_t sa, src_sel_t sb,
                                              sample_t seta, sample_t setb,
                                              logic loop, logic chan_b);
    sample_t in_a, in_b, out_a, out_b;
    out_a = route(sa, adc_sample(raw.a), adc_sample(raw.b), seta);
    out_b = route(sb, adc_sample(raw.a), adc_sample(raw.b), setb);
    if (loop)
    begin
      out_a = '0;   // settle from zero since only set and zero rooted paths occur
      out_b = '0;
      for (int i = 0; i < 3; i++)
      begin
        in_a  = out_a;
        in_b  = out_b;
        out_a = route(sa, in_a, in_b, seta);
        out_b = route(sb, in_a, in_b, setb);
      end
    end
    return dac_code(chan_b ? out_b : out_a);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks and bookkeeping
  //////////////////////////////////////////////////////////////////////

  task automatic check_code(string name, dac_code_t exp, dac_code_t act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("[FAIL] %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_rsp(string name, sys_rsp_t exp, sys_rsp_t act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("[FAIL] %s: expected rdata %h err %b ack %b, got rdata %h err %b ack %b",
               name, exp.rdata, exp.err, exp.ack, act.rdata, act.err, act.ack);
    end
  endtask

  task automatic check_led(string name, logic [7:0] exp, logic [7:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("[FAIL] %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic begin_test(string name);
    cur_test = name;
    err_mark = errors;
    chk_mark = checks;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != err_mark)
    begin
      tests_failed++;
      $display("test %s: %0d errors in %0d checks", cur_test, errors - err_mark,
               checks - chk_mark);
    end
    else
      $display("test %s: ok, %0d checks", cur_test, checks - chk_mark);
  endtask

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};   // one step per bit
    end
  endtask

  // compares the a phase while sel is low and the b phase while high
  always @(negedge adc_clk)
  begin
    if (check_en)
    begin
      if (!dac_sel_o)
        check_code($sformatf("%s ch a", cur_test), exp_a, dac_dat_o);
      else
        check_code($sformatf("%s ch b", cur_test), exp_b, dac_dat_o);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus and data path tasks
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] reg_addr(int region, logic [19:0] offs);
    return (32'(region) << `RP_REGION_LSB) | 32'(offs);
  endfunction

  // one strobe cycle with the address held until ack and the response sampled mid cycle
  task automatic bus_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          output sys_rsp_t rsp);
    int  n;
    logic got;
    n   = 0;
    got = 1'b0;
    rsp = '0;
    @(posedge adc_clk);
    #2;
    sys_req_i = '{addr: addr, wdata: wdata, sel: 4'hf, wen: wr, ren: !wr};
    while (!got && n < 8)
    begin
      @(negedge adc_clk);
      if (sys_rsp_o.ack)
      begin
        rsp = sys_rsp_o;
        got = 1'b1;
      end
      @(posedge adc_clk);
      #2;
      sys_req_i.wen = 1'b0;
      sys_req_i.ren = 1'b0;
      n++;
    end
    if (!got)
    begin
      errors++;
      $display("%s: no acknowledge for address %h within 8 cycles", cur_test, addr);
    end
  endtask

  task automatic cfg_write(int region, logic [19:0] offs, logic [31:0] data);
    sys_rsp_t rsp;
    bus_xfer(1'b1, reg_addr(region, offs), data, rsp);
    check_rsp($sformatf("%s write %h", cur_test, offs), '{rdata: 32'h0, err: 1'b0, ack: 1'b1},
              rsp);
  endtask

  task automatic set_route(src_sel_t sa, src_sel_t sb);
    cfg_write(`RP_ROUTER_REGION, `RP_REG_SEL_A, 32'(sa));
    cfg_write(`RP_ROUTER_REGION, `RP_REG_SEL_B, 32'(sb));
    sel_a = sa;
    sel_b = sb;
  endtask

  // wait for a steady path, then let the compare process see both phases
  task automatic settle_and_compare();
    exp_a = expected_code(adc_raw_i, sel_a, sel_b, set_a, set_b, loop_on, 1'b0);
    exp_b = expected_code(adc_raw_i, sel_a, sel_b, set_a, set_b, loop_on, 1'b1);
    repeat (10) @(posedge adc_clk);
    #2;
    check_en = 1'b1;
    repeat (2) @(posedge adc_clk);
    #2;
    check_en = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    sys_rsp_t    rsp;
    logic [31:0] v;
    logic        sel_prev;
    rst_n_i   = 1'b0;
    adc_raw_i = '0;
    sys_req_i = '0;
    check_en  = 1'b0;
    exp_a     = '0;
    exp_b     = '0;
    sel_a     = SRC_ADC_A;
    sel_b     = SRC_ADC_A;
    set_a     = '0;
    set_b     = '0;
    loop_on   = 1'b0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;

    begin_test("reset");
    repeat (5) @(posedge adc_clk);
    if (dac_rst_o !== 1'b1)
    begin
      errors++;
      $display("%s: dac_rst_o is not high while reset is asserted", cur_test);
    end
    #2 rst_n_i = 1'b1;
    repeat (2) @(posedge adc_clk);
    check_led("reset led", 8'h00, led_o);
    @(negedge adc_clk) sel_prev = dac_sel_o;
    if (dac_rst_o !== 1'b0)
    begin
      errors++;
      $display("%s: dac_rst_o stays high after reset is released", cur_test);
    end
    @(negedge adc_clk);
    if (dac_sel_o === sel_prev)
    begin
      errors++;
      $display("%s: dac_sel_o did not toggle between two cycles", cur_test);
    end
    set_route(SRC_ZERO, SRC_ZERO);
    settle_and_compare();
    end_test();

    begin_test("housekeeping");
    bus_xfer(1'b0, reg_addr(`RP_HK_REGION, `RP_REG_ID), 32'h0, rsp);
    check_rsp("id read", '{rdata: `RP_HK_ID, err: 1'b0, ack: 1'b1}, rsp);
    take_bits(8, v);
    cfg_write(`RP_HK_REGION, `RP_REG_LED, {24'h0, v[7:0]});
    bus_xfer(1'b0, reg_addr(`RP_HK_REGION, `RP_REG_LED), 32'h0, rsp);
    check_rsp("led read", '{rdata: {24'h0, v[7:0]}, err: 1'b0, ack: 1'b1}, rsp);
    check_led("led pins", v[7:0], led_o);
    bus_xfer(1'b1, reg_addr(`RP_HK_REGION, `RP_REG_ID), 32'hdead_beef, rsp);
    check_rsp("id write", '{rdata: 32'h0, err: 1'b1, ack: 1'b1}, rsp);
    end_test();

    begin_test("unused regions");
    for (int r = 1; r < `RP_N_REGIONS; r++)
    begin
      if (r != `RP_ROUTER_REGION)
      begin
        bus_xfer(1'b0, reg_addr(r, 20'h00010), 32'h0, rsp);
        check_rsp($sformatf("region %0d read", r), '{rdata: 32'h0, err: 1'b0, ack: 1'b1},
                  rsp);
      end
    end
    end_test();

    begin_test("routing");
    for (int s = 0; s < 4; s++)
    begin
      set_route(src_sel_t'(s), src_sel_t'(3 - s));   // pairs every source with another
      for (int i = 0; i < N_PAIRS; i++)
      begin
        take_bits(32, v);
        adc_raw_i = v;
        settle_and_compare();
      end
    end
    end_test();

    begin_test("set values");
    for (int i = 0; i < 5; i++)
    begin
      take_bits(14, v);
      set_a = sample_t'(v[13:0]);
      take_bits(14, v);
      set_b = sample_t'(v[13:0]);
      cfg_write(`RP_ROUTER_REGION, `RP_REG_SET_A, 32'(unsigned'(set_a)));
      cfg_write(`RP_ROUTER_REGION, `RP_REG_SET_B, 32'(unsigned'(set_b)));
      bus_xfer(1'b0, reg_addr(`RP_ROUTER_REGION, `RP_REG_SET_B), 32'h0, rsp);
      check_rsp("set b read", '{rdata: {18'h0, set_b}, err: 1'b0, ack: 1'b1}, rsp);
      set_route(SRC_SET, SRC_SET);
      settle_and_compare();
      set_route(SRC_ZERO, SRC_ZERO);
      settle_and_compare();
    end
    end_test();

    begin_test("digital loop");
    cfg_write(`RP_HK_REGION, `RP_REG_LOOP, 32'h1);
    loop_on = 1'b1;
    set_route(SRC_SET, SRC_SET);
    settle_and_compare();
    set_route(SRC_ADC_B, SRC_SET);   // a follows the looped b channel
    settle_and_compare();
    cfg_write(`RP_HK_REGION, `RP_REG_LOOP, 32'h0);
    loop_on = 1'b0;
    end_test();

    $display("tests run: %0d, tests failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge adc_clk);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
hdl/rp_pkg.sv
hdl/sys_bus_decoder.sv
hdl/housekeeping.sv
hdl/adc_frontend.sv
hdl/output_router.sv
hdl/dac_backend.sv
hdl/rp_analog_top.sv
test/tb_rp_analog_top.sv
